// ==== src/matrix_pool_pkg.sv ====
package matrix_pool_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 16;
    localparam int DIM_W = 6;

    // Register file word offsets, bus address bit 12 clear
    localparam logic [2:0] REG_SRC = 3'd0;
    localparam logic [2:0] REG_DST = 3'd1;
    localparam logic [2:0] REG_OROWS = 3'd2;
    localparam logic [2:0] REG_OCOLS = 3'd3;
    localparam logic [2:0] REG_WROWS = 3'd4;
    localparam logic [2:0] REG_WCOLS = 3'd5;
    localparam logic [2:0] REG_CTRL = 3'd6;
    localparam logic [2:0] REG_STATUS = 3'd7;

    typedef struct packed {
        logic [ADDR_W-1:0] src;
        logic [ADDR_W-1:0] dst;
        logic [DIM_W-1:0] orows;
        logic [DIM_W-1:0] ocols;
        logic [DIM_W-1:0] wrows;
        logic [DIM_W-1:0] wcols;
    } pool_cmd_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic signed [DATA_W-1:0] value;
        logic last;
    } pool_result_t;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [ADDR_W:0] adr;
        logic [DATA_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [DATA_W-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic en;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } spad_wr_t;

endpackage

// ==== src/matrix_fifo.sv ====
`timescale 1ns/1ns
module matrix_fifo #(
    parameter type payload_t = logic,
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic push,
    input  payload_t push_data,
    output logic full,
    input  logic pop,
    output payload_t pop_data,
    output logic empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;

    assign full = count == (PTR_W+1)'(DEPTH);
    assign empty = count == '0;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(push && full));
    assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

// ==== src/matrix_cmd_decode.sv ====
`timescale 1ns/1ns
module matrix_cmd_decode import matrix_pool_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic cmd_push,
    output pool_cmd_t cmd_data,
    input  logic cmd_full,
    input  logic busy,
    input  logic done_event,
    output logic [ADDR_W-1:0] host_rd_addr,
    input  logic [DATA_W-1:0] host_rd_data,
    output spad_wr_t host_wr,
    input  logic host_wr_grant
);
    pool_cmd_t params;
    logic [7:0] done_count;
    logic ack;
    logic ack_next;
    logic req;
    logic is_mem;
    logic reg_wr;
    logic [2:0] reg_off;
    logic rd_mem;
    logic [DATA_W-1:0] reg_rdata;

    // A request is new until it has been acked once
    assign req = wb_req.cyc && wb_req.stb && !ack;
    assign is_mem = wb_req.adr[ADDR_W];
    assign reg_off = wb_req.adr[2:0];
    assign reg_wr = req && wb_req.we && !is_mem;

    assign cmd_push = reg_wr && (reg_off == REG_CTRL) && !cmd_full;
    assign cmd_data = params;
    assign host_rd_addr = wb_req.adr[ADDR_W-1:0];

    always_comb begin
        host_wr.en = req && wb_req.we && is_mem;
        host_wr.addr = wb_req.adr[ADDR_W-1:0];
        host_wr.data = wb_req.dat_w;
    end

    always_comb begin
        wb_rsp.ack = ack;
        wb_rsp.dat_r = rd_mem ? host_rd_data : reg_rdata;
    end

    // Memory writes wait for the port, CTRL writes wait for queue space
    always_comb begin
        if (!req) begin
            ack_next = 1'b0;
        end else if (is_mem) begin
            ack_next = wb_req.we ? host_wr_grant : 1'b1;
        end else if (wb_req.we && reg_off == REG_CTRL) begin
            ack_next = !cmd_full;
        end else begin
            ack_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
            done_count <= '0;
            params <= '0;
        end else begin
            ack <= ack_next;
            if (done_event) begin
                done_count <= done_count + 1'b1;
            end
            if (reg_wr) begin
                case (reg_off)
                    REG_SRC: params.src <= wb_req.dat_w[ADDR_W-1:0];
                    REG_DST: params.dst <= wb_req.dat_w[ADDR_W-1:0];
                    REG_OROWS: params.orows <= wb_req.dat_w[DIM_W-1:0];
                    REG_OCOLS: params.ocols <= wb_req.dat_w[DIM_W-1:0];
                    REG_WROWS: params.wrows <= wb_req.dat_w[DIM_W-1:0];
                    REG_WCOLS: params.wcols <= wb_req.dat_w[DIM_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_mem <= is_mem;
        case (reg_off)
            REG_SRC: reg_rdata <= DATA_W'(params.src);
            REG_DST: reg_rdata <= DATA_W'(params.dst);
            REG_OROWS: reg_rdata <= DATA_W'(params.orows);
            REG_OCOLS: reg_rdata <= DATA_W'(params.ocols);
            REG_WROWS: reg_rdata <= DATA_W'(params.wrows);
            REG_WCOLS: reg_rdata <= DATA_W'(params.wcols);
            REG_STATUS: reg_rdata <= {busy, 7'b0, done_count};
            default: reg_rdata <= '0;
        endcase
    end

    // The master must hold cyc for the whole cycle
    assert property (@(posedge clk) disable iff (reset) wb_rsp.ack |-> wb_req.cyc);

endmodule

// ==== src/matrix_pool_engine.sv ====
`timescale 1ns/1ns
module matrix_pool_engine import matrix_pool_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic cmd_pop,
    input  pool_cmd_t cmd_data,
    input  logic cmd_empty,
    output logic [ADDR_W-1:0] rd_addr,
    input  logic signed [DATA_W-1:0] rd_data,
    output logic res_push,
    output pool_result_t res_data,
    input  logic res_full,
    output logic busy
);
    localparam logic signed [DATA_W-1:0] MAX_INIT = {1'b1, {(DATA_W-1){1'b0}}};

    pool_cmd_t cmd_q;
    logic active;
    logic rd_valid;
    logic rd_wlast;
    logic rd_clast;
    logic out_valid;
    logic out_last;
    logic stall;
    logic [DIM_W-1:0] orow, ocol, wrow, wcol;
    logic wcol_end, wrow_end, ocol_end, orow_end;
    logic [ADDR_W-1:0] stride;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] last_addr;
    logic [ADDR_W-1:0] row_start;
    logic [ADDR_W-1:0] win_start;
    logic [ADDR_W-1:0] next_win;
    logic [ADDR_W-1:0] dst_ptr;
    logic signed [DATA_W-1:0] max_q;
    logic signed [DATA_W-1:0] cur_max;
    logic signed [DATA_W-1:0] out_value;

    assign stall = out_valid && res_full;
    assign busy = active || rd_valid || out_valid;
    assign cmd_pop = !busy && !cmd_empty;
    assign res_push = out_valid && !res_full;

    // While stalled, re-read the word in flight so rd_data stays valid
    assign rd_addr = stall ? last_addr : rd_ptr;

    assign wcol_end = wcol == cmd_q.wcols - 1'b1;
    assign wrow_end = wrow == cmd_q.wrows - 1'b1;
    assign ocol_end = ocol == cmd_q.ocols - 1'b1;
    assign orow_end = orow == cmd_q.orows - 1'b1;

    // After the last window of a row, one past its last source row is the next row
    assign next_win = (ocol_end ? row_start : win_start) + ADDR_W'(cmd_q.wcols);
    assign cur_max = (rd_data > max_q) ? rd_data : max_q;

    always_comb begin
        res_data.addr = dst_ptr;
        res_data.value = out_value;
        res_data.last = out_last;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            rd_valid <= 1'b0;
            out_valid <= 1'b0;
        end else if (cmd_pop) begin
            active <= 1'b1;
        end else if (!stall) begin
            rd_valid <= active;
            out_valid <= rd_valid && rd_wlast;
            if (active && wcol_end && wrow_end && ocol_end && orow_end) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            cmd_q <= cmd_data;
            stride <= ADDR_W'(cmd_data.ocols) * ADDR_W'(cmd_data.wcols);
            rd_ptr <= cmd_data.src;
            row_start <= cmd_data.src;
            win_start <= cmd_data.src;
            dst_ptr <= cmd_data.dst;
            {orow, ocol, wrow, wcol} <= '0;
            max_q <= MAX_INIT;
        end else if (!stall) begin
            last_addr <= rd_ptr;
            rd_wlast <= wcol_end && wrow_end;
            rd_clast <= wcol_end && wrow_end && ocol_end && orow_end;
            if (active) begin
                if (!wcol_end) begin
                    wcol <= wcol + 1'b1;
                    rd_ptr <= rd_ptr + 1'b1;
                end else if (!wrow_end) begin
                    wcol <= '0;
                    wrow <= wrow + 1'b1;
                    row_start <= row_start + stride;
                    rd_ptr <= row_start + stride;
                end else begin
                    wcol <= '0;
                    wrow <= '0;
                    ocol <= ocol_end ? '0 : ocol + 1'b1;
                    orow <= ocol_end ? orow + 1'b1 : orow;
                    win_start <= next_win;
                    row_start <= next_win;
                    rd_ptr <= next_win;
                end
            end
            if (rd_valid) begin
                if (rd_wlast) begin
                    out_value <= cur_max;
                    out_last <= rd_clast;
                    max_q <= MAX_INIT;
                end else begin
                    max_q <= cur_max;
                end
            end
            if (res_push) begin
                dst_ptr <= dst_ptr + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        cmd_pop |-> (cmd_data.wrows != '0 && cmd_data.wcols != '0));

endmodule

// ==== src/matrix_result_writer.sv ====
`timescale 1ns/1ns
module matrix_result_writer import matrix_pool_pkg::*; (
    input  logic clk,
    input  logic reset,
    output logic res_pop,
    input  pool_result_t res_data,
    input  logic res_empty,
    output spad_wr_t wr,
    output logic done_event
);
    // Writer owns the port whenever it writes, so it never holds back
    assign res_pop = !res_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr.en <= 1'b0;
            done_event <= 1'b0;
        end else begin
            wr.en <= res_pop;
            done_event <= res_pop && res_data.last;
        end
    end

    always_ff @(posedge clk) begin
        if (res_pop) begin
            wr.addr <= res_data.addr;
            wr.data <= res_data.value;
        end
    end

endmodule

// ==== src/matrix_scratchpad.sv ====
`timescale 1ns/1ns
module matrix_scratchpad import matrix_pool_pkg::*; (
    input  logic clk,
    input  logic [ADDR_W-1:0] host_rd_addr,
    output logic [DATA_W-1:0] host_rd_data,
    input  logic [ADDR_W-1:0] eng_rd_addr,
    output logic signed [DATA_W-1:0] eng_rd_data,
    input  spad_wr_t wr_writer,
    input  spad_wr_t wr_host,
    output logic host_wr_grant
);
    logic [DATA_W-1:0] mem [1 << ADDR_W];

    // Result writes take the port first
    assign host_wr_grant = !wr_writer.en;

    always_ff @(posedge clk) begin
        host_rd_data <= mem[host_rd_addr];
        eng_rd_data <= mem[eng_rd_addr];
        if (wr_writer.en) begin
            mem[wr_writer.addr] <= wr_writer.data;
        end else if (wr_host.en) begin
            mem[wr_host.addr] <= wr_host.data;
        end
    end

endmodule

// ==== src/matrix_pool_top.sv ====
`timescale 1ns/1ns
module matrix_pool_top import matrix_pool_pkg::*; #(
    parameter int CMD_DEPTH = 2,
    parameter int RES_DEPTH = 4
) (
    input  logic clk,
    input  logic reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);
    pool_cmd_t cmd_push_data, cmd_pop_data;
    pool_result_t res_push_data, res_pop_data;
    logic cmd_push, cmd_full, cmd_pop, cmd_empty;
    logic res_push, res_full, res_pop, res_empty;
    logic eng_busy;
    logic busy;
    logic done_event;
    logic [ADDR_W-1:0] host_rd_addr, eng_rd_addr;
    logic [DATA_W-1:0] host_rd_data;
    logic signed [DATA_W-1:0] eng_rd_data;
    spad_wr_t host_wr, writer_wr;
    logic host_wr_grant;

    assign busy = eng_busy || !cmd_empty || !res_empty;

    matrix_cmd_decode decode0 (
        .clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp),
        .cmd_push(cmd_push), .cmd_data(cmd_push_data), .cmd_full(cmd_full),
        .busy(busy), .done_event(done_event),
        .host_rd_addr(host_rd_addr), .host_rd_data(host_rd_data),
        .host_wr(host_wr), .host_wr_grant(host_wr_grant)
    );

    matrix_fifo #(.payload_t(pool_cmd_t), .DEPTH(CMD_DEPTH)) cmd_fifo0 (
        .clk(clk), .reset(reset),
        .push(cmd_push), .push_data(cmd_push_data), .full(cmd_full),
        .pop(cmd_pop), .pop_data(cmd_pop_data), .empty(cmd_empty)
    );

    matrix_pool_engine engine0 (
        .clk(clk), .reset(reset),
        .cmd_pop(cmd_pop), .cmd_data(cmd_pop_data), .cmd_empty(cmd_empty),
        .rd_addr(eng_rd_addr), .rd_data(eng_rd_data),
        .res_push(res_push), .res_data(res_push_data), .res_full(res_full),
        .busy(eng_busy)
    );

    matrix_fifo #(.payload_t(pool_result_t), .DEPTH(RES_DEPTH)) res_fifo0 (
        .clk(clk), .reset(reset),
        .push(res_push), .push_data(res_push_data), .full(res_full),
        .pop(res_pop), .pop_data(res_pop_data), .empty(res_empty)
    );

    matrix_result_writer writer0 (
        .clk(clk), .reset(reset),
        .res_pop(res_pop), .res_data(res_pop_data), .res_empty(res_empty),
        .wr(writer_wr), .done_event(done_event)
    );

    matrix_scratchpad spad0 (
        .clk(clk),
        .host_rd_addr(host_rd_addr), .host_rd_data(host_rd_data),
        .eng_rd_addr(eng_rd_addr), .eng_rd_data(eng_rd_data),
        .wr_writer(writer_wr), .wr_host(host_wr), .host_wr_grant(host_wr_grant)
    );

endmodule

// ==== bench/matrix_pool_tb.sv ====
`timescale 1ns/1ns
module matrix_pool_tb import matrix_pool_pkg::*; ();

    localparam int BUS_TIMEOUT = 1000;
    localparam int POLL_LIMIT = 2000;

    logic clk;
    logic reset;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // Everything the testbench has written to the scratchpad
    logic signed [DATA_W-1:0] model_mem [1 << ADDR_W];
    int checks;
    int errors;
    int tests;
    bit timed_out;
    string test_name;

    matrix_pool_top #(.CMD_DEPTH(2), .RES_DEPTH(4)) dut0 (
        .clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic bus_access(input logic we, input logic [ADDR_W:0] adr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output int waited);
        waited = 0;
        rdata = '0;
        if (timed_out) begin
            return;
        end
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = adr;
        wb_req.dat_w = wdata;
        // ack is registered, so look just after each edge
        while (!wb_rsp.ack && waited < BUS_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wb_rsp.ack) begin
            rdata = wb_rsp.dat_r;
            // Hold the cycle through the edge that samples ack
            @(posedge clk);
            #1;
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
            wb_req.we = 1'b0;
        end else begin
            $display("ERROR %s: bus %s at address %h got no ack within %0d cycles",
                     test_name, we ? "write" : "read", adr, BUS_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic bus_write(input logic [ADDR_W:0] adr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_rdata;
        int waited;
        bus_access(1'b1, adr, data, unused_rdata, waited);
    endtask

    task automatic bus_read(input logic [ADDR_W:0] adr, output logic [DATA_W-1:0] data);
        int waited;
        bus_access(1'b0, adr, '0, data, waited);
    endtask

    function automatic logic [ADDR_W:0] reg_adr(input logic [2:0] off);
        return {{(ADDR_W-2){1'b0}}, off};
    endfunction

    function automatic logic [ADDR_W:0] mem_adr(input logic [ADDR_W-1:0] addr);
        return {1'b1, addr};
    endfunction

    task automatic mem_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        model_mem[addr] = data;
        bus_write(mem_adr(addr), data);
    endtask

    task automatic check_value(input string what, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        if (timed_out) begin
            return;
        end
        checks++;
        assert (actual == expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    // Random fill, sign bit forced when negative is set
    task automatic load_matrix(input logic [ADDR_W-1:0] base, input int rows, input int cols,
                               input bit negative);
        logic [DATA_W-1:0] value;
        for (int i = 0; i < rows * cols; i++) begin
            value = DATA_W'($urandom);
            if (negative) begin
                value[DATA_W-1] = 1'b1;
            end
            mem_write(base + ADDR_W'(i), value);
        end
    endtask

    function automatic logic signed [DATA_W-1:0] window_max(input int src, input int ocols,
            input int wrows, input int wcols, input int orow, input int ocol);
        logic signed [DATA_W-1:0] best;
        int stride;
        int addr;
        stride = ocols * wcols;
        best = model_mem[ADDR_W'(src + orow * wrows * stride + ocol * wcols)];
        for (int r = 0; r < wrows; r++) begin
            for (int c = 0; c < wcols; c++) begin
                addr = src + (orow * wrows + r) * stride + ocol * wcols + c;
                if (model_mem[ADDR_W'(addr)] > best) begin
                    best = model_mem[ADDR_W'(addr)];
                end
            end
        end
        return best;
    endfunction

    task automatic issue_command(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                                 input int orows, input int ocols, input int wrows,
                                 input int wcols, output int ctrl_wait);
        logic [DATA_W-1:0] unused_rdata;
        bus_write(reg_adr(REG_SRC), DATA_W'(src));
        bus_write(reg_adr(REG_DST), DATA_W'(dst));
        bus_write(reg_adr(REG_OROWS), DATA_W'(orows));
        bus_write(reg_adr(REG_OCOLS), DATA_W'(ocols));
        bus_write(reg_adr(REG_WROWS), DATA_W'(wrows));
        bus_write(reg_adr(REG_WCOLS), DATA_W'(wcols));
        bus_access(1'b1, reg_adr(REG_CTRL), '0, unused_rdata, ctrl_wait);
    endtask

    task automatic read_done_count(output logic [7:0] count);
        logic [DATA_W-1:0] status;
        bus_read(reg_adr(REG_STATUS), status);
        count = status[7:0];
    endtask

    task automatic wait_done(input logic [7:0] target);
        logic [DATA_W-1:0] status;
        int polls;
        polls = 0;
        bus_read(reg_adr(REG_STATUS), status);
        while (status[7:0] != target && polls < POLL_LIMIT && !timed_out) begin
            bus_read(reg_adr(REG_STATUS), status);
            polls++;
        end
        if (status[7:0] != target && !timed_out) begin
            $display("ERROR %s: done count stayed at %0d while waiting for %0d",
                     test_name, status[7:0], target);
            timed_out = 1'b1;
        end
    endtask

    task automatic check_status(input logic [7:0] target);
        logic [DATA_W-1:0] status;
        bus_read(reg_adr(REG_STATUS), status);
        check_value("done count", {8'h00, target}, {8'h00, status[7:0]});
        check_value("busy", '0, {15'h0000, status[15]});
    endtask

    task automatic check_output(input logic [ADDR_W-1:0] src, input logic [ADDR_W-1:0] dst,
                                input int orows, input int ocols, input int wrows,
                                input int wcols);
        logic [DATA_W-1:0] actual;
        logic signed [DATA_W-1:0] expected;
        logic [ADDR_W-1:0] addr;
        for (int r = 0; r < orows; r++) begin
            for (int c = 0; c < ocols; c++) begin
                expected = window_max(int'(src), ocols, wrows, wcols, r, c);
                addr = dst + ADDR_W'(r * ocols + c);
                bus_read(mem_adr(addr), actual);
                check_value($sformatf("out[%0d][%0d]", r, c), expected, actual);
                model_mem[addr] = expected;
            end
        end
    endtask

    task automatic finish_test(input int errors_before);
        tests++;
        $display("%s: %0d errors", test_name, errors - errors_before);
    endtask

    initial begin
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] written [6];
        logic [2:0] reg_offs [6];
        logic [7:0] done_before;
        int errors_before;
        int ctrl_wait;
        int last_wait;

        void'($urandom(79));
        checks = 0;
        errors = 0;
        tests = 0;
        timed_out = 1'b0;
        test_name = "reset";
        reset = 1'b1;
        wb_req = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "register readback";
        errors_before = errors;
        reg_offs = '{REG_SRC, REG_DST, REG_OROWS, REG_OCOLS, REG_WROWS, REG_WCOLS};
        for (int i = 0; i < 6; i++) begin
            written[i] = (i < 2) ? DATA_W'($urandom % 4096) : DATA_W'($urandom % 64);
            bus_write(reg_adr(reg_offs[i]), written[i]);
        end
        for (int i = 0; i < 6; i++) begin
            bus_read(reg_adr(reg_offs[i]), rdata);
            check_value($sformatf("reg %0d", i), written[i], rdata);
        end
        finish_test(errors_before);

        test_name = "scratchpad access";
        errors_before = errors;
        for (int i = 0; i < 16; i++) begin
            mem_write(ADDR_W'(12'h800 + i * 7), DATA_W'($urandom));
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(mem_adr(ADDR_W'(12'h800 + i * 7)), rdata);
            check_value($sformatf("word %0d", i), model_mem[ADDR_W'(12'h800 + i * 7)], rdata);
        end
        finish_test(errors_before);

        test_name = "basic pooling";
        errors_before = errors;
        load_matrix(12'h000, 8, 8, 1'b0);
        read_done_count(done_before);
        issue_command(12'h000, 12'h400, 4, 4, 2, 2, ctrl_wait);
        wait_done(done_before + 8'd1);
        check_status(done_before + 8'd1);
        check_output(12'h000, 12'h400, 4, 4, 2, 2);
        finish_test(errors_before);

        test_name = "negative and 1x1 windows";
        errors_before = errors;
        load_matrix(12'h100, 4, 6, 1'b1);
        // First window holds nothing but the most negative value
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 3; c++) begin
                mem_write(12'h100 + ADDR_W'(r * 6 + c), 16'h8000);
            end
        end
        read_done_count(done_before);
        issue_command(12'h100, 12'h480, 2, 2, 2, 3, ctrl_wait);
        wait_done(done_before + 8'd1);
        check_status(done_before + 8'd1);
        check_output(12'h100, 12'h480, 2, 2, 2, 3);
        load_matrix(12'h180, 3, 5, 1'b0);
        read_done_count(done_before);
        issue_command(12'h180, 12'h4c0, 3, 5, 1, 1, ctrl_wait);
        wait_done(done_before + 8'd1);
        check_status(done_before + 8'd1);
        check_output(12'h180, 12'h4c0, 3, 5, 1, 1);
        finish_test(errors_before);

        test_name = "queued commands";
        errors_before = errors;
        load_matrix(12'h000, 16, 16, 1'b0);
        load_matrix(12'h100, 9, 8, 1'b0);
        load_matrix(12'h200, 8, 8, 1'b1);
        load_matrix(12'h300, 5, 3, 1'b0);
        read_done_count(done_before);
        issue_command(12'h000, 12'h600, 8, 8, 2, 2, ctrl_wait);
        issue_command(12'h100, 12'h700, 3, 4, 3, 2, ctrl_wait);
        issue_command(12'h200, 12'h740, 2, 2, 4, 4, ctrl_wait);
        issue_command(12'h300, 12'h760, 5, 1, 1, 3, last_wait);
        // Engine still on the first command, two more queued
        checks++;
        assert (timed_out || last_wait > 1) else begin
            $display("ERROR %s: last CTRL write was acked after %0d cycle without queue space",
                     test_name, last_wait);
            errors++;
        end
        wait_done(done_before + 8'd4);
        check_status(done_before + 8'd4);
        check_output(12'h000, 12'h600, 8, 8, 2, 2);
        check_output(12'h100, 12'h700, 3, 4, 3, 2);
        check_output(12'h200, 12'h740, 2, 2, 4, 4);
        check_output(12'h300, 12'h760, 5, 1, 1, 3);
        finish_test(errors_before);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== matrix_pool_top.f ====
src/matrix_pool_pkg.sv
src/matrix_fifo.sv
src/matrix_cmd_decode.sv
src/matrix_pool_engine.sv
src/matrix_result_writer.sv
src/matrix_scratchpad.sv
src/matrix_pool_top.sv
bench/matrix_pool_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, pass only when the pass message shows up
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ns \
        --top-module matrix_pool_tb -f matrix_pool_top.f -o matrix_pool_sim \
    && ./obj_dir/matrix_pool_sim | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
